// ==== verilog.f ====
sdram_pkg.sv
sdram_slot_timer.sv
sdram_host_port.sv
sdram_cmd_gen.sv
sdram_ctrl.sv
sdram_chip_model.sv
tb_sdram_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_sdram_ctrl
RTL_TOP   = sdram_ctrl
FILELIST  = verilog.f
RTL_FILES = sdram_pkg.sv sdram_slot_timer.sv sdram_host_port.sv sdram_cmd_gen.sv sdram_ctrl.sv
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_sdram_ctrl.sv ====
// directed tests at CAS latency 2 and ACTIVE-to-READ 3; the model stands in for the chip
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl
	import sdram_pkg::*;
();

	localparam int CAS_LATENCY     = 2;
	localparam int RASCAS_DELAY    = 3;
	localparam int NUM_REQUESTS    = 2 + 40 + 6 + 1;	// over all tests
	localparam int WATCHDOG_CYCLES = 5 + 32 * 8 + 40 * NUM_REQUESTS + 10 * 8;
	localparam host_addr_t KNOWN_ADDR = 25'h0a53c7e;	// written by the first access test

	logic       clk;
	logic       reset;
	logic       req_valid;
	logic       req_ready;
	logic       req_write;
	host_addr_t req_addr;
	host_data_t req_wdata;
	logic       rsp_valid;
	host_data_t rsp_rdata;
	logic       sd_cs;
	logic       sd_ras;
	logic       sd_cas;
	logic       sd_we;
	sd_addr_t   sd_addr;
	sd_ba_t     sd_ba;
	logic [1:0] sd_dqm;
	sd_data_t   sd_dq_out;
	logic       sd_dq_oe;
	sd_data_t   sd_dq_in;

	int model_errs;
	int precharge_count;
	int mode_count;
	int active_count;
	int access_count;
	int refresh_count;
	sd_addr_t mode_word;

	int err_count;
	int errs_at_start;	// error total when the current test began
	int tests_run;
	int tests_failed;
	int seed;
	host_data_t rsp_q [$];	// read responses in arrival order
	host_data_t ref_mem [logic [23:0]];	// expected byte per mapped word

	sdram_ctrl #(
		.CAS_LATENCY  (CAS_LATENCY),
		.RASCAS_DELAY (RASCAS_DELAY)
	) u_sdram_ctrl (.*);

	sdram_chip_model #(
		.CAS_LATENCY (CAS_LATENCY)
	) u_chip (
		.clk, .reset, .cs(sd_cs), .ras(sd_ras), .cas(sd_cas), .we(sd_we),
		.addr(sd_addr), .ba(sd_ba), .dqm(sd_dqm), .dq_in(sd_dq_out), .dq_oe(sd_dq_oe),
		.dq_out(sd_dq_in), .err_count(model_errs), .precharge_count, .mode_count,
		.active_count, .access_count, .refresh_count, .mode_word
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 125 MHz
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	always @(negedge clk) begin
		if (rsp_valid) rsp_q.push_back(rsp_rdata);	// collect every response strobe
	end

	// --------------------
	// helpers
	// --------------------

	// bank 22..21, row 20..8, column {23, 7..0}; bit 24 drops out
	function automatic logic [23:0] map_key(input host_addr_t a);
		return {a[22:21], a[20:8], a[23], a[7:0]};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			err_count++;
			$display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_count + model_errs - errs_at_start;
		tests_run++;
		if (errs != 0) tests_failed++;
		$display("%s: %0d error(s)", name, errs);
		errs_at_start = err_count + model_errs;
	endtask

	// leaves req_valid high, returns one negedge after the transfer edge
	task automatic send_request(input logic write, input host_addr_t a, input host_data_t d);
		req_valid = 1'b1;
		req_write = write;
		req_addr  = a;
		req_wdata = d;
		while (!req_ready) @(negedge clk);
		@(negedge clk);
	endtask

	task automatic host_write(input host_addr_t a, input host_data_t d);
		send_request(1'b1, a, d);
		req_valid = 1'b0;
		ref_mem[map_key(a)] = d;
	endtask

	task automatic host_read(input string name, input host_addr_t a);
		host_data_t got;
		send_request(1'b0, a, '0);
		req_valid = 1'b0;
		while (rsp_q.size() == 0) @(negedge clk);
		got = rsp_q.pop_front();
		check(name, ref_mem[map_key(a)], got);
	endtask

	// --------------------
	// tests
	// --------------------

	task automatic power_up_sequence();
		int cyc;
		cyc = 0;
		while (!req_ready) begin
			@(negedge clk);
			cyc++;
		end
		if (cyc < 31 * 8) begin
			err_count++;
			$display("power_up: req_ready rose after %0d cycles, before init ended", cyc);
		end
		check("power_up precharge", 1, precharge_count);
		check("power_up load_mode", 1, mode_count);
		check("power_up active", 0, active_count);	// none before init ends
		check("power_up burst length", 0, mode_word[2:0]);
		check("power_up write mode", 1, mode_word[9]);
		check("power_up cas latency", CAS_LATENCY, mode_word[6:4]);
	endtask

	task automatic bank_row_mapping();
		host_addr_t addrs [20];
		logic [23:0] key;
		for (int i = 0; i < 20; i++) begin
			addrs[i] = host_addr_t'($random(seed));
			host_write(addrs[i], host_data_t'($random(seed)));
		end
		// odd entries read through the bit 24 alias
		for (int i = 0; i < 20; i++) begin
			host_read("mapping", (i % 2 == 1) ? (addrs[i] ^ 25'h1000000) : addrs[i]);
			// the word has to sit at the bank, row and column the mapping names
			key = map_key(addrs[i]);
			if (!u_chip.mem.exists(key)) begin
				err_count++;
				$display("mapping: nothing stored at bank %0d row 0x%0h column 0x%0h",
					key[23:22], key[21:9], key[8:0]);
			end else begin
				check("mapping placement", {2{ref_mem[key]}}, u_chip.mem[key]);
			end
		end
	endtask

	task automatic back_to_back();
		host_addr_t a [3];
		host_data_t d [3];
		int base_active;
		int base_access;
		a[0] = host_addr_t'($random(seed));
		a[1] = a[0] ^ 25'h0200000;	// other bank
		a[2] = a[0] ^ 25'h0000100;	// other row
		for (int i = 0; i < 3; i++) d[i] = host_data_t'($random(seed));
		base_active = active_count;
		base_access = access_count;
		send_request(1'b1, a[0], d[0]);	// valid stays high throughout
		send_request(1'b1, a[1], d[1]);
		send_request(1'b0, a[0], '0);
		send_request(1'b0, a[1], '0);
		send_request(1'b1, a[2], d[2]);
		send_request(1'b0, a[2], '0);
		req_valid = 1'b0;
		for (int i = 0; i < 3; i++) ref_mem[map_key(a[i])] = d[i];
		while (rsp_q.size() < 3) @(negedge clk);
		repeat (16) @(negedge clk);	// room for a stray extra strobe
		check("back_to_back responses", 3, rsp_q.size());
		for (int i = 0; i < 3 && rsp_q.size() > 0; i++) check("back_to_back data", d[i],
			rsp_q.pop_front());
		check("back_to_back accepts", 6, active_count - base_active);
		check("back_to_back accesses", 6, access_count - base_access);
	endtask

	task automatic idle_refresh();
		int base_refresh;
		int base_active;
		int base_access;
		repeat (16) @(negedge clk);
		base_refresh = refresh_count;
		base_active  = active_count;
		base_access  = access_count;
		repeat (10 * 8) @(negedge clk);	// ten slots
		check("idle_refresh refreshes", 10, refresh_count - base_refresh);
		check("idle_refresh actives", 0, active_count - base_active);
		check("idle_refresh accesses", 0, access_count - base_access);
	endtask

	task automatic read_latency();
		int cyc;
		int active_at;
		host_data_t got;
		cyc       = 0;
		active_at = -1;
		repeat (16) @(negedge clk);	// start from an idle bus
		send_request(1'b0, KNOWN_ADDR, '0);
		req_valid = 1'b0;
		while (!rsp_valid) begin
			@(negedge clk);
			cyc++;
			if (active_at < 0 && {sd_cs, sd_ras, sd_cas, sd_we} == CMD_ACTIVE) active_at = cyc;
		end
		check("read_latency cycles", RASCAS_DELAY + CAS_LATENCY + 1, cyc - active_at);
		while (rsp_q.size() == 0) @(negedge clk);
		got = rsp_q.pop_front();
		check("read_latency data", ref_mem[map_key(KNOWN_ADDR)], got);
	endtask

	// --------------------
	// main sequence
	// --------------------

	initial begin
		reset         = 1'b1;
		req_valid     = 1'b0;
		req_write     = 1'b0;
		req_addr      = '0;
		req_wdata     = '0;
		err_count     = 0;
		errs_at_start = 0;
		tests_run     = 0;
		tests_failed  = 0;
		seed          = 10;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		power_up_sequence();
		end_test("power_up");
		host_write(KNOWN_ADDR, 8'h5a);
		host_read("write_read", KNOWN_ADDR);
		end_test("write_read");
		bank_row_mapping();
		end_test("mapping");
		back_to_back();
		end_test("back_to_back");
		idle_refresh();
		end_test("idle_refresh");
		read_latency();
		end_test("read_latency");

		$display("%0d tests, %0d failed, %0d check errors, %0d model errors",
			tests_run, tests_failed, err_count, model_errs);
		if (err_count == 0 && model_errs == 0 && tests_failed == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sdram_chip_model.sv ====
// behavioural sdram for simulation only; tracks bank state and data, no ac timing checks
`timescale 1ns/1ps
`default_nettype none

module sdram_chip_model
	import sdram_pkg::*;
#(
	parameter int CAS_LATENCY = 2	// must match the controller
) (
	input  wire logic       clk,
	input  wire logic       reset,	// clears the bookkeeping, commands ignored
	input  wire logic       cs,
	input  wire logic       ras,
	input  wire logic       cas,
	input  wire logic       we,
	input  wire sd_addr_t   addr,
	input  wire sd_ba_t     ba,
	input  wire logic [1:0] dqm,
	input  wire sd_data_t   dq_in,	// write data from the controller
	input  wire logic       dq_oe,
	output sd_data_t        dq_out,	// read data back to the controller
	output int              err_count,
	output int              precharge_count,	// precharge-all only
	output int              mode_count,
	output int              active_count,
	output int              access_count,	// reads plus writes
	output int              refresh_count,
	output sd_addr_t        mode_word	// last mode register value
);

	sd_cmd_e     cmd;
	logic [3:0]  bank_open;
	logic [12:0] open_row [4];
	sd_data_t    mem [logic [23:0]];	// sparse, only written words
	sd_data_t    rd_pipe [CAS_LATENCY];	// stage 0 loads on READ
	logic [23:0] key;	// {bank, row, column}
	sd_data_t    rd_word;

	assign cmd    = sd_cmd_e'({cs, ras, cas, we});
	assign dq_out = rd_pipe[CAS_LATENCY-1];	// valid CAS_LATENCY edges after READ

	// words never written read back as a pattern of the whole address
	function automatic sd_data_t fill_word(input logic [23:0] k);
		return {k[23:16] ^ k[7:0], k[15:8] ^ k[7:0]};
	endfunction

	task automatic report_error(input string what);
		err_count = err_count + 1;
		$display("chip model error at %0t: %s", $time, what);
	endtask

	// --------------------
	// command decode
	// --------------------

	always @(posedge clk) begin
		rd_word = '0;
		if (reset) begin
			err_count       = 0;
			precharge_count = 0;
			mode_count      = 0;
			active_count    = 0;
			access_count    = 0;
			refresh_count   = 0;
			bank_open       = '0;
			mode_word       = '0;
		end else begin
			// the data bus is only driven with a WRITE
			if (dq_oe && cmd != CMD_WRITE) report_error("data bus driven outside a WRITE");
			case (cmd)
				CMD_ACTIVE: begin
					if (mode_count == 0) report_error("ACTIVE before LOAD MODE");
					if (bank_open[ba]) report_error("ACTIVE to a bank with a row already open");
					bank_open[ba] = 1'b1;
					open_row[ba]  = addr;
					active_count  = active_count + 1;
				end
				CMD_READ, CMD_WRITE: begin
					if (mode_count == 0) report_error("READ or WRITE before LOAD MODE");
					if (!bank_open[ba]) report_error("READ or WRITE to a bank with no open row");
					key = {ba, open_row[ba], addr[8:0]};
					if (cmd == CMD_WRITE) begin
						if (!dq_oe) report_error("WRITE without the data bus driven");
						if (dqm != 2'b00) report_error("WRITE with byte masks set");
						mem[key] = dq_in;
					end else begin
						rd_word = mem.exists(key) ? mem[key] : fill_word(key);
					end
					if (addr[10]) bank_open[ba] = 1'b0;	// auto-precharge
					access_count = access_count + 1;
				end
				CMD_PRECHARGE: begin
					if (addr[10]) begin
						bank_open       = '0;	// all banks
						precharge_count = precharge_count + 1;
					end else begin
						bank_open[ba] = 1'b0;
					end
				end
				CMD_AUTO_REFRESH: begin
					if (bank_open != '0) report_error("AUTO REFRESH with a row still open");
					refresh_count = refresh_count + 1;
				end
				CMD_LOAD_MODE: begin
					if (precharge_count == 0) report_error("LOAD MODE before PRECHARGE-ALL");
					if (bank_open != '0) report_error("LOAD MODE with a row still open");
					mode_word  = addr;
					mode_count = mode_count + 1;
				end
				CMD_BURST_TERMINATE: report_error("unexpected BURST TERMINATE");
				default: ;	// INHIBIT and NOP
			endcase
		end
		// read data pipe, zero when nothing is returning
		for (int i = CAS_LATENCY - 1; i > 0; i--) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
		rd_pipe[0] <= rd_word;
	end

endmodule

`default_nettype wire

// ==== sdram_ctrl.sv ====
// sdram controller top; data bus split into out/in/oe, the pad tri-state sits outside
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl
	import sdram_pkg::*;
#(
	parameter int CAS_LATENCY  = 2,	// 2 or 3
	parameter int RASCAS_DELAY = 3	// 2 to 4 cycles
) (
	input  wire logic       clk,
	input  wire logic       reset,
	// host request and response
	input  wire logic       req_valid,
	output logic            req_ready,
	input  wire logic       req_write,
	input  wire host_addr_t req_addr,
	input  wire host_data_t req_wdata,
	output logic            rsp_valid,
	output host_data_t      rsp_rdata,
	// chip pins
	output logic            sd_cs,
	output logic            sd_ras,
	output logic            sd_cas,
	output logic            sd_we,
	output sd_addr_t        sd_addr,
	output sd_ba_t          sd_ba,
	output logic [1:0]      sd_dqm,
	output sd_data_t        sd_dq_out,
	output logic            sd_dq_oe,
	input  wire sd_data_t   sd_dq_in
);

	slot_phase_t phase;
	init_count_t init_count;
	logic        init_done;
	logic        pend;		// request held for a slot
	logic        pend_write;
	host_addr_t  pend_addr;
	host_data_t  pend_wdata;

	sdram_slot_timer u_slot_timer (
		.clk, .reset, .phase, .init_count, .init_done
	);

	sdram_host_port #(
		.CAS_LATENCY  (CAS_LATENCY),
		.RASCAS_DELAY (RASCAS_DELAY)
	) u_host_port (
		.clk, .reset, .phase, .init_done,
		.req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
		.rsp_valid, .rsp_rdata,
		.pend, .pend_write, .pend_addr, .pend_wdata,
		.sd_dq_in
	);

	sdram_cmd_gen #(
		.CAS_LATENCY  (CAS_LATENCY),
		.RASCAS_DELAY (RASCAS_DELAY)
	) u_cmd_gen (
		.clk, .reset, .phase, .init_count, .init_done,
		.pend, .pend_write, .pend_addr, .pend_wdata,
		.sd_cs, .sd_ras, .sd_cas, .sd_we,
		.sd_addr, .sd_ba, .sd_dqm, .sd_dq_out, .sd_dq_oe
	);

endmodule

`default_nettype wire

// ==== sdram_cmd_gen.sv ====
// single access with auto-precharge per slot, refresh in idle slots; masks always clear
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_gen
	import sdram_pkg::*;
#(
	parameter int CAS_LATENCY  = 2,	// written into the mode word
	parameter int RASCAS_DELAY = 3	// phase of the READ/WRITE decision
) (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire slot_phase_t phase,
	input  wire init_count_t init_count,
	input  wire logic        init_done,
	// held request
	input  wire logic        pend,
	input  wire logic        pend_write,
	input  wire host_addr_t  pend_addr,
	input  wire host_data_t  pend_wdata,
	// chip pins
	output logic             sd_cs,
	output logic             sd_ras,
	output logic             sd_cas,
	output logic             sd_we,
	output sd_addr_t         sd_addr,
	output sd_ba_t           sd_ba,
	output logic [1:0]       sd_dqm,
	output sd_data_t         sd_dq_out,
	output logic             sd_dq_oe
);

	localparam slot_phase_t CMD_PHASE     = slot_phase_t'(RASCAS_DELAY);
	localparam sd_addr_t    PRECHARGE_ALL = 13'h0400;	// a10 set, all banks

	// mode word as {reserved, write mode, op mode, cas latency, order, burst}
	localparam sd_addr_t MODE_WORD = {3'b000, MODE_SINGLE_WRITE, MODE_STD_OP,
		3'(CAS_LATENCY), MODE_SEQUENTIAL, MODE_BURST_LEN};

	sd_cmd_e  cmd_q;		// command on the pins
	sd_cmd_e  cmd_next;
	sd_addr_t addr_next;
	sd_ba_t   ba_next;
	logic     oe_next;
	logic     access_slot;	// ACTIVE was issued in this slot
	sd_addr_t row_addr;
	sd_addr_t col_addr;

	// --------------------
	// address mapping
	// --------------------

	assign row_addr = pend_addr[20:8];
	// a10 high asks for auto-precharge after the access
	assign col_addr = {2'b00, 1'b1, 1'b0, pend_addr[23], pend_addr[7:0]};

	// --------------------
	// command decode
	// --------------------

	always_comb begin
		cmd_next  = CMD_INHIBIT;	// deselect unless something below fires
		addr_next = row_addr;
		ba_next   = pend_addr[22:21];
		oe_next   = 1'b0;
		if (!init_done) begin
			ba_next = '0;	// mode register is bank 0
			if (phase == PH_IDLE) begin
				if (init_count == INIT_PRECHARGE_AT) begin
					cmd_next  = CMD_PRECHARGE;
					addr_next = PRECHARGE_ALL;
				end else if (init_count == INIT_MODE_AT) begin
					cmd_next  = CMD_LOAD_MODE;
					addr_next = MODE_WORD;
				end
			end
		end else if (phase == PH_IDLE) begin
			// one decision per slot, access or refresh
			cmd_next = pend ? CMD_ACTIVE : CMD_AUTO_REFRESH;
		end else if (phase == CMD_PHASE && access_slot) begin
			addr_next = col_addr;
			if (pend_write) begin
				cmd_next = CMD_WRITE;
				oe_next  = 1'b1;	// drive data with the command
			end else begin
				cmd_next = CMD_READ;
			end
		end
	end

	// only a slot that opened a row may read or write
	always_ff @(posedge clk) begin
		if (reset) begin
			access_slot <= 1'b0;
		end else if (phase == PH_IDLE) begin
			access_slot <= init_done && pend;
		end
	end

	// --------------------
	// pin registers
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_q    <= CMD_INHIBIT;
			sd_dq_oe <= 1'b0;
		end else begin
			cmd_q    <= cmd_next;
			sd_dq_oe <= oe_next;
		end
	end

	// address and data follow the command, one cycle after decode
	always_ff @(posedge clk) begin
		sd_addr   <= addr_next;
		sd_ba     <= ba_next;
		sd_dq_out <= {pend_wdata, pend_wdata};	// byte on both lanes
	end

	assign sd_cs  = cmd_q[3];
	assign sd_ras = cmd_q[2];
	assign sd_cas = cmd_q[1];
	assign sd_we  = cmd_q[0];

	assign sd_dqm = 2'b00;	// no lane masking

endmodule

`default_nettype wire

// ==== sdram_host_port.sv ====
// one request held per slot, reads answered after a fixed latency with no back-pressure
`timescale 1ns/1ps
`default_nettype none

module sdram_host_port
	import sdram_pkg::*;
#(
	parameter int CAS_LATENCY  = 2,	// must match the mode word
	parameter int RASCAS_DELAY = 3	// ACTIVE to READ/WRITE in cycles
) (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire slot_phase_t phase,
	input  wire logic        init_done,
	// request channel
	input  wire logic        req_valid,
	output logic             req_ready,
	input  wire logic        req_write,
	input  wire host_addr_t  req_addr,
	input  wire host_data_t  req_wdata,
	// read response
	output logic             rsp_valid,
	output host_data_t       rsp_rdata,
	// held request towards the command generator
	output logic             pend,
	output logic             pend_write,
	output host_addr_t       pend_addr,
	output host_data_t       pend_wdata,
	// chip read data
	input  wire sd_data_t    sd_dq_in
);

	// pipe length so the last stage lines up with the sample cycle
	localparam int RD_LAT = RASCAS_DELAY + CAS_LATENCY + 1;

	logic              accept;		// handshake completes this cycle
	logic              serving;		// held request owns the current slot
	logic              rd_start;	// read begins in this slot
	logic [RD_LAT-1:0] rd_pipe;	// one bit per read in flight

	// --------------------
	// request capture
	// --------------------

	// never ready in phase 0, the generator decides on pend there
	assign req_ready = init_done && !pend && (phase != PH_IDLE);
	assign accept    = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			pend    <= 1'b0;
			serving <= 1'b0;
		end else begin
			if (accept) begin
				pend <= 1'b1;
			end else if (phase == PH_LAST && serving) begin
				pend <= 1'b0;	// served slot ends, free for next request
			end
			// a request taken mid-slot waits for the next phase 0
			if (phase == PH_IDLE) begin
				serving <= pend;
			end else if (phase == PH_LAST) begin
				serving <= 1'b0;
			end
		end
	end

	// request payload, only written on a handshake
	always_ff @(posedge clk) begin
		if (accept) begin
			pend_write <= req_write;
			pend_addr  <= req_addr;
			pend_wdata <= req_wdata;
		end
	end

	// --------------------
	// read return
	// --------------------

	// starts on the ACTIVE decision, same phase the generator uses
	assign rd_start = (phase == PH_IDLE) && pend && !pend_write;

	// a shift pipe lets the previous read finish while
	// the next slot already serves another request
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_pipe   <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rd_pipe   <= {rd_pipe[RD_LAT-2:0], rd_start};
			rsp_valid <= rd_pipe[RD_LAT-1];	// single cycle strobe
		end
	end

	// low lane only, high lane carries the same byte on writes
	always_ff @(posedge clk) begin
		if (rd_pipe[RD_LAT-1]) begin
			rsp_rdata <= sd_dq_in[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== sdram_slot_timer.sv ====
// free-running slot phase from reset, no reference clock sync; power-up lasts 31 full slots
`timescale 1ns/1ps
`default_nettype none

module sdram_slot_timer
	import sdram_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    reset,
	output slot_phase_t  phase,		// cycle inside the current slot
	output init_count_t  init_count,	// power-up slots left
	output logic         init_done	// power-up finished, requests allowed
);

	// --------------------
	// slot phase
	// --------------------

	// the slot never stalls, one full turn every eight clocks
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_IDLE;
		end else if (phase == PH_LAST) begin
			phase <= PH_IDLE;	// wrap into next slot
		end else begin
			phase <= slot_phase_t'(phase + 3'd1);
		end
	end

	// --------------------
	// power-up countdown
	// --------------------

	// counts whole slots, so the precharge and mode steps
	// always land on phase 0 of their slot
	always_ff @(posedge clk) begin
		if (reset) begin
			init_count <= INIT_SLOTS;
		end else if (phase == PH_LAST && init_count != '0) begin
			init_count <= init_count - 5'd1;	// one slot done
		end
	end

	// zero count ends power-up and stays there until the next reset
	assign init_done = (init_count == '0);

endmodule

`default_nettype wire

// ==== sdram_pkg.sv ====
// shared types for the 16-bit x4-bank sdram controller; single access only, no bursts, no masks
`default_nettype none

package sdram_pkg;

	// --------------------
	// host side vectors
	// --------------------

	typedef logic [24:0] host_addr_t;	// byte address, bit 24 ignored by the mapping
	typedef logic [7:0]  host_data_t;	// one byte per request

	// --------------------
	// chip side vectors
	// --------------------

	typedef logic [12:0] sd_addr_t;	// multiplexed row / column / mode address
	typedef logic [1:0]  sd_ba_t;	// bank select
	typedef logic [15:0] sd_data_t;	// full chip data word, two byte lanes

	// chip commands as {cs, ras, cas, we}, all active low
	typedef enum logic [3:0] {
		CMD_INHIBIT         = 4'b1111,	// chip deselected
		CMD_NOP             = 4'b0111,
		CMD_ACTIVE          = 4'b0011,	// open a row
		CMD_READ            = 4'b0101,
		CMD_WRITE           = 4'b0100,
		CMD_BURST_TERMINATE = 4'b0110,
		CMD_PRECHARGE       = 4'b0010,	// a10 high closes all banks
		CMD_AUTO_REFRESH    = 4'b0001,
		CMD_LOAD_MODE       = 4'b0000	// mode word on the address bus
	} sd_cmd_e;

	// --------------------
	// slot timing
	// --------------------

	// position inside the eight cycle slot
	typedef enum logic [2:0] {
		PH_IDLE = 3'd0,	// slot decision, ACTIVE / refresh / init step
		PH_ROW  = 3'd1,	// first command is on the pins here
		PH_2    = 3'd2,
		PH_3    = 3'd3,
		PH_4    = 3'd4,
		PH_5    = 3'd5,
		PH_6    = 3'd6,
		PH_LAST = 3'd7	// slot end, request released
	} slot_phase_t;

	typedef logic [4:0] init_count_t;	// power-up slots still to go

	localparam init_count_t INIT_SLOTS        = 5'd31;	// countdown start after reset
	localparam init_count_t INIT_PRECHARGE_AT = 5'd13;	// precharge-all slot
	localparam init_count_t INIT_MODE_AT      = 5'd2;	// load mode slot

	// fixed fields of the mode word, cas latency is added by the generator
	localparam logic [2:0] MODE_BURST_LEN    = 3'b000;	// single access
	localparam logic       MODE_SEQUENTIAL   = 1'b0;	// sequential order
	localparam logic [1:0] MODE_STD_OP       = 2'b00;	// standard operation
	localparam logic       MODE_SINGLE_WRITE = 1'b1;	// writes never burst

endpackage

`default_nettype wire
